/* logic/scopePkg.sv */
// Scope command definitions
`default_nettype none

package scopePkg;

	typedef logic [7:0] byteT; // one serial byte

	localparam int ramWidth = 12; // capture address width
	typedef logic [ramWidth-1:0] pointT; // trigger point inside capture ram

	localparam int chanCount = 4; // channels per board
	typedef logic [chanCount-1:0] chanMaskT; // one bit per channel

	localparam int maxArgs = 2; // longest argument list of any opcode

	typedef struct packed {
		byteT opcode; // command byte
		logic [1:0] argCount; // how many args below are valid
		byteT [maxArgs-1:0] args; // args[0] is the first byte after the opcode
	} cmdFrameT;

	// opcodes
	localparam byteT opRollOn = 8'd101;
	localparam byteT opRollOff = 8'd102;
	localparam byteT opTrigPoint = 8'd121;
	localparam byteT opThresh = 8'd127;
	localparam byteT opTrigType = 8'd128;
	localparam byteT opDelayRead = 8'd132; // tdc delay counter
	localparam byteT opCarryRead = 8'd133; // tdc carry counter
	localparam byteT opGainToggle = 8'd134;
	localparam byteT opOffsetSet = 8'd135;

	// chain id ranges, each idSpan wide
	localparam byteT idBase = 8'd0; // assign board id
	localparam byteT readBase = 8'd10; // read board out
	localparam byteT lastBase = 8'd20; // mark last board
	localparam byteT idSpan = 8'd10;

	localparam pointT trigPointMin = pointT'(4);
	localparam pointT trigPointMax = pointT'(2**ramWidth - 16); // keeps room after the trigger

	// power-up settings
	localparam byteT defaultId = 8'd200; // not yet in a chain
	localparam pointT defaultTrigPoint = pointT'(1024); // quarter of the buffer
	localparam byteT defaultThresh = 8'h80; // mid scale
	localparam logic [3:0] defaultTrigType = 4'b0001; // rising edge
	localparam byteT defaultOffset = 8'd58; // about 22.7 percent duty

	localparam int pwmPrescale = 2; // phase steps every pwmPrescale+1 clocks
	localparam int pwmPreWidth = $clog2(pwmPrescale + 1);

	// number of argument bytes that follow an opcode
	function automatic logic [1:0] argBytesFor(input byteT op);
		case (op)
			opTrigPoint, opOffsetSet: argBytesFor = 2'd2;
			opThresh, opTrigType, opGainToggle: argBytesFor = 2'd1;
			default: argBytesFor = 2'd0; // bare opcodes and unknown bytes
		endcase
	endfunction

endpackage

`default_nettype wire

/* logic/cmdFramer.sv */
// Command byte framer
`timescale 1ns/1ps
`default_nettype none

module cmdFramer (
	input wire clk,
	input wire arstN,
	input wire scopePkg::byteT rxData, // byte from the uart receiver
	input wire rxReady, // one cycle per received byte
	output scopePkg::cmdFrameT frame,
	output logic frameValid,
	input wire frameReady
);

	scopePkg::cmdFrameT pending; // frame being gathered
	scopePkg::cmdFrameT completed; // pending with the current byte merged in
	logic collecting; // opcode seen, still waiting for args
	logic [1:0] argIdx; // next argument slot
	logic [1:0] newCount; // arg count of an incoming opcode
	logic lastArg; // current arg byte completes the frame
	logic frameDone;

	assign newCount = scopePkg::argBytesFor(rxData);
	assign lastArg = (argIdx + 2'd1) == pending.argCount;
	assign frameDone = rxReady && (collecting ? lastArg : (newCount == 2'd0));

	always_comb begin
		completed = pending;
		if (!collecting) begin
			completed.opcode = rxData; // fresh opcode
			completed.argCount = newCount;
			completed.args = '0; // unused slots read as zero
		end else begin
			completed.args[argIdx[0]] = rxData;
		end
	end

	// payload, no reset needed
	always_ff @(posedge clk) begin
		if (rxReady) begin
			pending <= completed;
		end
		if (frameDone) begin
			frame <= completed; // offered the cycle after the last byte
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			collecting <= 1'b0;
			argIdx <= 2'd0;
			frameValid <= 1'b0;
		end else begin
			if (frameValid && frameReady) begin
				frameValid <= 1'b0; // taken downstream
			end
			if (frameDone) begin
				frameValid <= 1'b1;
			end
			if (rxReady) begin
				if (collecting) begin
					argIdx <= argIdx + 2'd1;
					if (lastArg) begin
						collecting <= 1'b0; // back to opcode hunting
					end
				end else begin
					argIdx <= 2'd0;
					collecting <= (newCount != 2'd0); // opcode with args
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/pipeStage.sv */
// One-entry valid/ready stage
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
	parameter type payloadT = logic [7:0]
) (
	input wire clk,
	input wire arstN,
	input wire payloadT inData,
	input wire inValid,
	output logic inReady,
	output payloadT outData,
	output logic outValid,
	input wire outReady
);

	// empty, or draining this cycle
	assign inReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			outData <= inData; // payload, unreset
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			if (inValid && inReady) begin
				outValid <= 1'b1; // offered one cycle after accept
			end else if (outReady) begin
				outValid <= 1'b0; // taken, nothing new behind it
			end
		end
	end

endmodule

`default_nettype wire

/* logic/cmdExecutor.sv */
// Command executor and board settings
`timescale 1ns/1ps
`default_nettype none

module cmdExecutor (
	input wire clk,
	input wire arstN,
	input wire scopePkg::cmdFrameT frame,
	input wire frameValid,
	output logic frameReady,
	input wire scopePkg::byteT delayCounter, // tdc data for replies
	input wire scopePkg::byteT carryCounter,
	output scopePkg::byteT comData, // byte to the next board
	output logic newComData,
	output scopePkg::byteT replyData,
	output logic replyValid,
	input wire replyReady,
	output scopePkg::byteT myId,
	output logic imTheFirst,
	output logic imTheLast,
	output logic [1:0] masterClock, // 0 own master, 1 slave
	output logic serialPassthrough,
	output logic rollingTrigger,
	output scopePkg::pointT triggerPoint,
	output scopePkg::byteT trigThresh,
	output logic [3:0] triggerType,
	output scopePkg::chanMaskT gainSw,
	output scopePkg::byteT [scopePkg::chanCount-1:0] offsetDuty
);

	scopePkg::byteT op;
	scopePkg::byteT idOff, readOff, lastOff; // wrap below base, so one compare per range
	scopePkg::byteT [scopePkg::maxArgs-1:0] fwdArgs; // args still to forward
	logic [1:0] fwdPos, fwdCount; // forwarding progress
	logic fwdBusy, take;
	logic fwdEn, replyEn; // decode results for the current frame
	scopePkg::byteT fwdFirst, replyByte;
	logic ownsChan; // channel number belongs to this board
	logic [1:0] chanSel;
	logic [15:0] rawPoint;
	scopePkg::pointT clampPoint;

	assign op = frame.opcode;
	assign idOff = op - scopePkg::idBase;
	assign readOff = op - scopePkg::readBase;
	assign lastOff = op - scopePkg::lastBase;
	assign fwdBusy = fwdPos != fwdCount;
	assign take = frameValid && frameReady;
	assign frameReady = !fwdBusy && (!replyValid || replyReady); // stall on full reply
	assign imTheFirst = (myId == 8'd0);
	assign ownsChan = ({2'b00, frame.args[0][7:2]} == myId); // arg div 4
	assign chanSel = frame.args[0][1:0]; // arg mod 4
	assign rawPoint = {frame.args[0], frame.args[1]};

	always_comb begin
		if (rawPoint > 16'(scopePkg::trigPointMax)) begin
			clampPoint = scopePkg::trigPointMax;
		end else if (rawPoint < 16'(scopePkg::trigPointMin)) begin
			clampPoint = scopePkg::trigPointMin;
		end else begin
			clampPoint = rawPoint[scopePkg::ramWidth-1:0];
		end
	end

	// what goes down the chain and what gets answered
	always_comb begin
		fwdEn = 1'b0;
		fwdFirst = op;
		replyEn = 1'b0;
		replyByte = (op == scopePkg::opCarryRead) ? carryCounter : delayCounter;
		if (idOff < scopePkg::idSpan) begin
			fwdEn = 1'b1;
			fwdFirst = op + 8'd1; // next board gets the next id
		end else if (readOff < scopePkg::idSpan) begin
			fwdEn = (readOff != myId); // not us, pass it on
		end else if (lastOff < scopePkg::idSpan) begin
			fwdEn = 1'b1;
		end else begin
			case (op)
				scopePkg::opRollOn, scopePkg::opRollOff, scopePkg::opTrigPoint,
				scopePkg::opThresh, scopePkg::opTrigType, scopePkg::opGainToggle,
				scopePkg::opOffsetSet: fwdEn = 1'b1;
				scopePkg::opDelayRead, scopePkg::opCarryRead: begin
					fwdEn = serialPassthrough;
					replyEn = !serialPassthrough; // we are being read out
				end
				default: fwdEn = 1'b0; // unknown, dropped
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (take) begin
			comData <= fwdFirst;
			fwdArgs <= frame.args;
			replyData <= replyByte;
		end else if (fwdBusy) begin
			comData <= fwdArgs[fwdPos[0]];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			newComData <= 1'b0;
			fwdPos <= 2'd0;
			fwdCount <= 2'd0;
			replyValid <= 1'b0;
			myId <= scopePkg::defaultId;
			imTheLast <= 1'b0;
			masterClock <= 2'b00;
			serialPassthrough <= 1'b0;
			rollingTrigger <= 1'b1;
			triggerPoint <= scopePkg::defaultTrigPoint;
			trigThresh <= scopePkg::defaultThresh;
			triggerType <= scopePkg::defaultTrigType;
			gainSw <= '0; // low gain on all channels
			offsetDuty <= {scopePkg::chanCount{scopePkg::defaultOffset}};
		end else begin
			newComData <= 1'b0;
			if (replyValid && replyReady) begin
				replyValid <= 1'b0;
			end
			if (fwdBusy) begin
				newComData <= 1'b1; // one argument per cycle
				fwdPos <= fwdPos + 2'd1;
			end
			if (take) begin
				newComData <= fwdEn; // opcode goes first
				fwdPos <= 2'd0;
				fwdCount <= fwdEn ? frame.argCount : 2'd0;
				if (replyEn) begin
					replyValid <= 1'b1;
				end
				if (idOff < scopePkg::idSpan) begin
					myId <= idOff;
					masterClock <= (idOff == 8'd0) ? 2'b00 : 2'b01;
				end else if (readOff < scopePkg::idSpan) begin
					serialPassthrough <= (readOff != myId);
				end else if (lastOff < scopePkg::idSpan) begin
					imTheLast <= (lastOff == myId);
				end else begin
					case (op)
						scopePkg::opRollOn: rollingTrigger <= 1'b1;
						scopePkg::opRollOff: rollingTrigger <= 1'b0;
						scopePkg::opTrigPoint: triggerPoint <= clampPoint;
						scopePkg::opThresh: trigThresh <= frame.args[0];
						scopePkg::opTrigType: triggerType <= frame.args[0][3:0];
						scopePkg::opGainToggle: if (ownsChan) gainSw[chanSel] <= !gainSw[chanSel];
						scopePkg::opOffsetSet: if (ownsChan) offsetDuty[chanSel] <= frame.args[1];
						default: ; // reads and unknown opcodes keep settings
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/replySerializer.sv */
// Reply byte serializer
`timescale 1ns/1ps
`default_nettype none

module replySerializer (
	input wire clk,
	input wire arstN,
	input wire scopePkg::byteT replyData,
	input wire replyValid,
	output logic replyReady,
	input wire txBusy, // uart transmitter still shifting
	output logic txStart,
	output scopePkg::byteT txData
);

	logic full; // holding a byte for the transmitter
	logic gap; // cycle right after a start

	assign replyReady = !full && !gap;
	assign txStart = full && !txBusy; // first free cycle

	always_ff @(posedge clk) begin
		if (replyValid && replyReady) begin
			txData <= replyData; // held until started
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
			gap <= 1'b0;
		end else begin
			gap <= txStart; // lets busy rise before the next byte
			if (replyValid && replyReady) begin
				full <= 1'b1;
			end else if (txStart) begin
				full <= 1'b0; // released to the uart
			end
		end
	end

endmodule

`default_nettype wire

/* logic/offsetPwm.sv */
// Channel offset PWM
`timescale 1ns/1ps
`default_nettype none

module offsetPwm (
	input wire clk,
	input wire arstN,
	input wire scopePkg::byteT [scopePkg::chanCount-1:0] offsetDuty, // high time out of 256
	output scopePkg::chanMaskT offset
);

	logic [scopePkg::pwmPreWidth-1:0] preCount; // slows the phase down
	scopePkg::byteT phase; // free-running pwm phase

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			preCount <= '0;
			phase <= '0;
		end else begin
			if (preCount == scopePkg::pwmPreWidth'(scopePkg::pwmPrescale)) begin
				preCount <= '0;
				phase <= phase + 8'd1; // wraps every 256 steps
			end else begin
				preCount <= preCount + 1'b1;
			end
		end
	end

	// comparators, rc filtered on the board
	for (genvar ch = 0; ch < scopePkg::chanCount; ch++) begin : gComp
		assign offset[ch] = offsetDuty[ch] > phase;
	end

endmodule

`default_nettype wire

/* logic/scopeController.sv */
// Scope command processor top
`timescale 1ns/1ps
`default_nettype none

module scopeController (
	input wire clk,
	input wire arstN,
	input wire scopePkg::byteT rxData,
	input wire rxReady,
	input wire txBusy,
	output logic txStart,
	output scopePkg::byteT txData,
	input wire scopePkg::byteT delayCounter,
	input wire scopePkg::byteT carryCounter,
	output scopePkg::byteT comData,
	output logic newComData,
	output scopePkg::byteT myId,
	output logic imTheFirst,
	output logic imTheLast,
	output logic [1:0] masterClock,
	output logic serialPassthrough,
	output logic rollingTrigger,
	output scopePkg::pointT triggerPoint,
	output scopePkg::byteT trigThresh,
	output logic [3:0] triggerType,
	output scopePkg::chanMaskT gainSw,
	output scopePkg::chanMaskT offset
);

	scopePkg::cmdFrameT rawFrame, stagedFrame; // framer side, executor side
	logic rawValid, rawReady, stagedValid, stagedReady;
	scopePkg::byteT execReply, stagedReply;
	logic execReplyValid, execReplyReady, stagedReplyValid, stagedReplyReady;
	scopePkg::byteT [scopePkg::chanCount-1:0] offsetDuty;

	cmdFramer framer (
		.clk(clk), .arstN(arstN), .rxData(rxData), .rxReady(rxReady),
		.frame(rawFrame), .frameValid(rawValid), .frameReady(rawReady)
	);

	pipeStage #(.payloadT(scopePkg::cmdFrameT)) frameStage (
		.clk(clk), .arstN(arstN),
		.inData(rawFrame), .inValid(rawValid), .inReady(rawReady),
		.outData(stagedFrame), .outValid(stagedValid), .outReady(stagedReady)
	);

	cmdExecutor executor (
		.clk(clk), .arstN(arstN),
		.frame(stagedFrame), .frameValid(stagedValid), .frameReady(stagedReady),
		.delayCounter(delayCounter), .carryCounter(carryCounter),
		.comData(comData), .newComData(newComData),
		.replyData(execReply), .replyValid(execReplyValid), .replyReady(execReplyReady),
		.myId(myId), .imTheFirst(imTheFirst), .imTheLast(imTheLast),
		.masterClock(masterClock), .serialPassthrough(serialPassthrough),
		.rollingTrigger(rollingTrigger), .triggerPoint(triggerPoint),
		.trigThresh(trigThresh), .triggerType(triggerType),
		.gainSw(gainSw), .offsetDuty(offsetDuty)
	);

	pipeStage #(.payloadT(scopePkg::byteT)) replyStage (
		.clk(clk), .arstN(arstN),
		.inData(execReply), .inValid(execReplyValid), .inReady(execReplyReady),
		.outData(stagedReply), .outValid(stagedReplyValid), .outReady(stagedReplyReady)
	);

	replySerializer serializer (
		.clk(clk), .arstN(arstN),
		.replyData(stagedReply), .replyValid(stagedReplyValid), .replyReady(stagedReplyReady),
		.txBusy(txBusy), .txStart(txStart), .txData(txData)
	);

	offsetPwm pwm (
		.clk(clk), .arstN(arstN), .offsetDuty(offsetDuty), .offset(offset)
	);

endmodule

`default_nettype wire

/* verification/scopeController_checker.sv */
// Scope controller protocol checks
`timescale 1ns/1ps
`default_nettype none

module scopeController_checker (
	input wire clk,
	input wire arstN,
	input wire txBusy,
	input wire txStart,
	input wire newComData,
	input wire scopePkg::pointT triggerPoint
);

	int failures = 0; // failed assertions so far

	// start is a single strobe per reply byte
	txStartPulse: assert property (@(posedge clk) disable iff (!arstN)
		txStart |=> !txStart)
		else begin
			failures++;
			$error("txStart stayed high for more than one cycle");
		end

	// a forwarding burst is the opcode plus at most maxArgs arguments
	comBurstLength: assert property (@(posedge clk) disable iff (!arstN)
		(newComData && $past(newComData) && $past(newComData, 2)) |=> !newComData)
		else begin
			failures++;
			$error("newComData burst longer than one frame");
		end

	// transmitter must be idle
	txStartIdle: assert property (@(posedge clk) disable iff (!arstN)
		txBusy |-> !txStart)
		else begin
			failures++;
			$error("txStart while txBusy was high");
		end

	triggerInRange: assert property (@(posedge clk) disable iff (!arstN)
		(triggerPoint >= scopePkg::trigPointMin) && (triggerPoint <= scopePkg::trigPointMax))
		else begin
			failures++;
			$error("triggerPoint outside its clamp range");
		end

endmodule

bind scopeController scopeController_checker protocolChecks (
	.clk(clk), .arstN(arstN), .txBusy(txBusy), .txStart(txStart),
	.newComData(newComData), .triggerPoint(triggerPoint)
);

`default_nettype wire

/* verification/scopeController_tb.sv */
// Scope controller testbench
`timescale 1ns/1ps
`default_nettype none

module scopeController_tb;

	localparam int stepMax = 256; // steps the data file may hold
	localparam int stepWidth = 5; // kind, selector, three values
	localparam int waitLimit = 200; // cycles before a wait gives up
	localparam int pwmWindow = 768; // one full pwm period, 3 x 256

	logic clk;
	logic arstN;
	scopePkg::byteT rxData;
	logic rxReady;
	logic txBusy;
	logic txStart;
	scopePkg::byteT txData;
	scopePkg::byteT delayCounter;
	scopePkg::byteT carryCounter;
	scopePkg::byteT comData;
	logic newComData;
	scopePkg::byteT myId;
	logic imTheFirst;
	logic imTheLast;
	logic [1:0] masterClock;
	logic serialPassthrough;
	logic rollingTrigger;
	scopePkg::pointT triggerPoint;
	scopePkg::byteT trigThresh;
	logic [3:0] triggerType;
	scopePkg::chanMaskT gainSw;
	scopePkg::chanMaskT offset;

	scopePkg::byteT steps [0:stepMax*stepWidth-1]; // flat copy of the data file
	scopePkg::byteT fwdQ [$]; // bytes seen with newComData
	scopePkg::byteT txQ [$]; // bytes seen with txStart

	scopeController UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// outputs are taken at the rising edge, inputs move on the falling one
	always @(posedge clk) begin
		if (newComData) fwdQ.push_back(comData);
		if (txStart) txQ.push_back(txData);
	end

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compareByte(input string name, input scopePkg::byteT got,
			input scopePkg::byteT exp);
		if (got !== exp) reportFailure($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	task automatic comparePoint(input string name, input scopePkg::pointT got,
			input scopePkg::pointT exp);
		if (got !== exp) reportFailure($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	task automatic compareMask(input string name, input scopePkg::chanMaskT got,
			input scopePkg::chanMaskT exp);
		if (got !== exp) reportFailure($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
			$time, name, got, exp));
	endtask

	task automatic compareCount(input string name, input int got, input int exp);
		if (got != exp) reportFailure($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
			$time, name, got, exp));
	endtask

	// one rx pulse, then a random idle gap as from a real uart
	task automatic sendByte(input scopePkg::byteT b);
		rxData = b;
		rxReady = 1'b1;
		@(negedge clk);
		rxReady = 1'b0;
		repeat (16 + $urandom_range(24)) @(negedge clk);
	endtask

	task automatic expectForward(input scopePkg::byteT exp);
		int waited = 0;
		while (fwdQ.size() == 0 && waited < waitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (fwdQ.size() == 0) reportFailure("timed out waiting for a byte down the chain");
		compareByte("comData", fwdQ.pop_front(), exp);
	endtask

	task automatic expectReply(input scopePkg::byteT exp);
		int waited = 0;
		while (txQ.size() == 0 && waited < waitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (txQ.size() == 0) reportFailure("timed out waiting for txStart");
		compareByte("txData", txQ.pop_front(), exp);
	endtask

	task automatic expectQuiet();
		if (fwdQ.size() != 0) reportFailure("a byte went down the chain that should not have");
		if (txQ.size() != 0) reportFailure("a reply was started that should not have been");
	endtask

	task automatic checkSetting(input scopePkg::byteT sel, input scopePkg::byteT hi,
			input scopePkg::byteT lo);
		case (sel)
			8'd0: compareByte("myId", myId, lo);
			8'd1: compareByte("masterClock", scopePkg::byteT'(masterClock), lo);
			8'd2: compareByte("imTheFirst", scopePkg::byteT'(imTheFirst), lo);
			8'd3: compareByte("imTheLast", scopePkg::byteT'(imTheLast), lo);
			8'd4: compareByte("serialPassthrough", scopePkg::byteT'(serialPassthrough), lo);
			8'd5: compareByte("rollingTrigger", scopePkg::byteT'(rollingTrigger), lo);
			8'd6: comparePoint("triggerPoint", triggerPoint, scopePkg::pointT'({hi, lo}));
			8'd7: compareByte("trigThresh", trigThresh, lo);
			8'd8: compareByte("triggerType", scopePkg::byteT'(triggerType), lo);
			8'd9: compareMask("gainSw", gainSw, scopePkg::chanMaskT'(lo));
			default: reportFailure("the test file names a setting that does not exist");
		endcase
	endtask

	task automatic driveInput(input scopePkg::byteT sel, input scopePkg::byteT val);
		case (sel)
			8'd0: begin
				if (val != 8'd0) begin
					txBusy = 1'b1;
				end else begin
					repeat (8 + $urandom_range(40)) @(negedge clk); // random extra busy time
					txBusy = 1'b0;
				end
			end
			8'd1: delayCounter = val;
			8'd2: carryCounter = val;
			default: reportFailure("the test file names an input that does not exist");
		endcase
	endtask

	// pwm is periodic, so any full window gives the exact high count
	task automatic countOffset(input scopePkg::byteT ch, input int exp);
		int high = 0;
		repeat (pwmWindow) begin
			@(negedge clk);
			if (offset[ch[1:0]]) high++;
		end
		compareCount($sformatf("offset[%0d] high cycles", ch), high, exp);
	endtask

	initial begin
		int idx;
		int base;
		scopePkg::byteT kind;
		scopePkg::byteT sel;
		void'($urandom(32'h81bd));
		arstN = 1'b0;
		rxData = 8'h00;
		rxReady = 1'b0;
		txBusy = 1'b0;
		delayCounter = 8'h00;
		carryCounter = 8'h00;
		for (idx = 0; idx < stepMax*stepWidth; idx++) steps[idx] = 8'hFF; // unread is bad kind
		$readmemh("verification/scopeController_tests.txt", steps);
		repeat (16) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		for (idx = 0; idx < stepMax && steps[idx*stepWidth] != 8'h00; idx++) begin
			base = idx * stepWidth;
			kind = steps[base];
			sel = steps[base+1];
			case (kind)
				8'd1: for (int k = 0; k < int'(sel); k++) sendByte(steps[base+2+k]);
				8'd2: for (int k = 0; k < int'(sel); k++) expectForward(steps[base+2+k]);
				8'd3: expectReply(steps[base+2]);
				8'd4: checkSetting(sel, steps[base+2], steps[base+3]);
				8'd5: driveInput(sel, steps[base+2]);
				8'd6: expectQuiet();
				8'd7: countOffset(sel, {steps[base+2], steps[base+3]});
				default: reportFailure($sformatf("test file step %0d has an unknown kind", idx));
			endcase
		end
		if (idx == stepMax) reportFailure("test file ran out without an end step");
		expectQuiet(); // nothing left over at the end
		if (UUT.protocolChecks.failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/scopeController_tests.txt */
// columns: kind, count or selector, three hex values; kinds 1 send, 2 forwarded, 3 reply,
// 4 setting sel = hi lo, 5 input sel = value, 6 nothing pending, 7 offset high count, 0 end
5 1 5A 00 00
5 2 C3 00 00
1 1 03 00 00
2 1 04 00 00
4 0 00 03 00
4 1 00 01 00
4 2 00 00 00
1 1 00 00 00
2 1 01 00 00
4 2 00 01 00
4 1 00 00 00
1 1 03 00 00
2 1 04 00 00
1 1 0C 00 00
2 1 0C 00 00
4 4 00 01 00
1 1 84 00 00
2 1 84 00 00
6 0 00 00 00
1 1 0D 00 00
6 0 00 00 00
4 4 00 00 00
5 0 01 00 00
1 1 85 00 00
6 0 00 00 00
5 0 00 00 00
3 0 C3 00 00
1 1 84 00 00
3 0 5A 00 00
1 1 17 00 00
2 1 17 00 00
4 3 00 01 00
1 3 79 00 01
2 3 79 00 01
4 6 00 04 00
1 3 79 0F FF
2 3 79 0F FF
4 6 0F F0 00
1 2 7F 3C 00
2 2 7F 3C 00
4 7 00 3C 00
1 2 80 A5 00
2 2 80 A5 00
4 8 00 05 00
1 1 66 00 00
2 1 66 00 00
4 5 00 00 00
1 1 65 00 00
2 1 65 00 00
4 5 00 01 00
1 1 01 00 00
2 1 02 00 00
1 2 86 06 00
2 2 86 06 00
4 9 00 04 00
1 2 86 02 00
2 2 86 02 00
4 9 00 04 00
1 3 87 05 40
2 3 87 05 40
7 1 00 C0 00
7 0 00 AE 00
7 2 00 AE 00
7 3 00 AE 00
1 1 63 00 00
6 0 00 00 00
4 7 00 3C 00
1 2 7F 11 00
2 2 7F 11 00
4 7 00 11 00
0 0 00 00 00

/* vlog.f */
logic/scopePkg.sv
logic/cmdFramer.sv
logic/pipeStage.sv
logic/cmdExecutor.sv
logic/replySerializer.sv
logic/offsetPwm.sv
logic/scopeController.sv
verification/scopeController_checker.sv
verification/scopeController_tb.sv

/* Makefile */
SIM := obj_dir/VscopeController_tb
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "run ended without a result"; exit 1)

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module scopeController_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log
